// File: rtl/red_pkg.sv
// Shared reduction types; header mask is fixed at red_max_routes bits, payload is one 32-bit word
package red_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Upper bound on input routes and width of the header mask
  localparam int unsigned red_max_routes = 8;

  // Index width for n entries, never below one bit
  function automatic int unsigned red_idx_w(int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // ------------------------------
  // Encodings
  // ------------------------------

  // Reduction operation, code 2'd3 is reserved and behaves as select_aw
  typedef enum logic [1:0] {
    select_aw = 2'd0,
    lsb_and   = 2'd1,
    collect_b = 2'd2
  } red_op_e;

  // Write response codes, AXI encoding
  typedef enum logic [1:0] {
    okay   = 2'd0,
    exokay = 2'd1,
    slverr = 2'd2,
    decerr = 2'd3
  } red_resp_e;

  // ------------------------------
  // Flit layout
  // ------------------------------

  // Header carries the expected-route mask directly
  typedef struct packed {
    red_op_e                   red_op;
    logic [red_max_routes-1:0] red_mask;
    logic [5:0]                tag;
  } red_hdr_t;

  // Write-data view of the payload word
  typedef struct packed {
    logic [31:0] data;
  } red_w_payload_t;

  // Response view, resp sits in the low bits
  typedef struct packed {
    logic [23:0] rsvd;
    logic [5:0]  id;
    red_resp_e   resp;
  } red_b_payload_t;

  // Same word, decoded by operation
  typedef union packed {
    red_w_payload_t w;
    red_b_payload_t b;
  } red_payload_u;

  typedef struct packed {
    red_hdr_t     hdr;
    red_payload_u payload;
  } red_flit_t;

endpackage

// File: rtl/red_operand_if.sv
// Operand bundle from control to combiners; purely combinational, valid only while a lead exists
`timescale 1ns/1ps

interface red_operand_if #(
  parameter int unsigned NumRoutes = 4
);

  localparam int unsigned SelW = red_pkg::red_idx_w(NumRoutes);

  // All input flits as seen at the ports
  red_pkg::red_flit_t [NumRoutes-1:0] flits;
  // Participants, lead mask cut down to NumRoutes
  logic [NumRoutes-1:0]               mask;
  // Index of the lead input
  logic [SelW-1:0]                    sel;
  // Operation taken from the lead header
  red_pkg::red_op_e                   op;

  // Control side drives everything
  modport ctrl_mp (
    output flits, mask, sel, op
  );

  // Combiners only read
  modport comb_mp (
    input flits, mask, sel, op
  );

endinterface

// File: rtl/red_sync_ctrl.sv
// Group control is combinational; assumes stable inputs while valid, consistent headers, NumRoutes at most 8
`timescale 1ns/1ps

module red_sync_ctrl #(
  parameter int unsigned NumRoutes = 4
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic               [NumRoutes-1:0] valid_i,
  output logic               [NumRoutes-1:0] ready_o,
  input  red_pkg::red_flit_t [NumRoutes-1:0] data_i,
  red_operand_if.ctrl_mp                     ops,
  input  red_pkg::red_flit_t                 b_flit_i,
  input  red_pkg::red_flit_t                 w_flit_i,
  output logic                               push_o,
  output red_pkg::red_flit_t                 flit_o,
  input  logic                               full_i
);

  localparam int unsigned SelW = red_pkg::red_idx_w(NumRoutes);

  logic [SelW-1:0]      sel;
  logic                 any_valid;
  red_pkg::red_flit_t   lead;
  logic [NumRoutes-1:0] mask;
  logic                 complete;
  logic                 fire;

  // ------------------------------
  // Lead selection
  // ------------------------------

  // Priority search, scan downward so the lowest valid index wins
  always_comb begin
    sel = '0;
    for (int i = NumRoutes - 1; i >= 0; i--) begin
      if (valid_i[i]) begin
        sel = SelW'(i);
      end
    end
  end

  assign any_valid = |valid_i;
  assign lead      = data_i[sel];

  // Expected participants come straight from the lead header
  // No lead means no participants
  assign mask = any_valid ? lead.hdr.red_mask[NumRoutes-1:0] : '0;

  // ------------------------------
  // Completeness and firing
  // ------------------------------

  // Every masked route must be present
  assign complete = ((valid_i & mask) == mask);

  // Empty mask never fires, full queue holds the inputs back
  assign fire = complete && (|mask) && !full_i;

  // Accept exactly the participants, nobody else
  assign ready_o = fire ? mask : '0;

  // Operands for the combiners
  assign ops.flits = data_i;
  assign ops.mask  = mask;
  assign ops.sel   = sel;
  assign ops.op    = lead.hdr.red_op;

  // ------------------------------
  // Result selection
  // ------------------------------

  // collect_b has its own merger; forward, lsb_and and reserved go through the W path
  always_comb begin
    if (lead.hdr.red_op == red_pkg::collect_b) begin
      flit_o = b_flit_i;
    end else begin
      flit_o = w_flit_i;
    end
  end

  assign push_o = fire;

endmodule

// File: rtl/red_collect_b.sv
// Response merger; first slverr in index order wins, decerr gets no priority over okay
`timescale 1ns/1ps

module red_collect_b (
  red_operand_if.comb_mp      ops,
  output red_pkg::red_flit_t  b_flit_o
);

  red_pkg::red_payload_u pay;
  logic                  found;

  // ------------------------------
  // Error scan
  // ------------------------------

  // Default is the lead flit
  // Masked routes are walked lowest first, a slverr replaces the whole flit
  always_comb begin
    b_flit_o = ops.flits[ops.sel];
    found    = 1'b0;
    pay      = '0;
    for (int i = 0; i < $bits(ops.mask); i++) begin
      if (ops.mask[i] && !found) begin
        // Read the word as a response
        pay = ops.flits[i].payload;
        if (pay.b.resp == red_pkg::slverr) begin
          b_flit_o = ops.flits[i];
          found    = 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/red_w_combine.sv
// Forward and LSB-AND path; output is all zero when EnParallel is 0
`timescale 1ns/1ps

module red_w_combine #(
  parameter bit EnParallel = 1'b1
) (
  red_operand_if.comb_mp      ops,
  output red_pkg::red_flit_t  w_flit_o
);

  red_pkg::red_flit_t lead;
  logic               lsb;

  // ------------------------------
  // Bit 0 reduction
  // ------------------------------

  // AND of data bit 0 over all participants
  always_comb begin
    lsb = 1'b1;
    for (int i = 0; i < $bits(ops.mask); i++) begin
      if (ops.mask[i]) begin
        lsb &= ops.flits[i].payload.w.data[0];
      end
    end
  end

  assign lead = ops.flits[ops.sel];

  // ------------------------------
  // Output select
  // ------------------------------

  always_comb begin
    w_flit_o = '0;
    if (EnParallel) begin
      w_flit_o = lead;
      case (ops.op)
        // Lead flit with the reduced bit patched in
        red_pkg::lsb_and: w_flit_o.payload.w.data[0] = lsb;
        // select_aw and reserved code pass the lead unchanged
        default: w_flit_o = lead;
      endcase
    end
  end

endmodule

// File: rtl/red_out_fifo.sv
// Result queue; push on full and push with pop on full are not allowed by the caller
`timescale 1ns/1ps

module red_out_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               push_i,
  input  red_pkg::red_flit_t flit_i,
  output logic               full_o,
  output logic               valid_o,
  input  logic               ready_i,
  output red_pkg::red_flit_t data_o
);

  localparam int unsigned PtrW = red_pkg::red_idx_w(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  red_pkg::red_flit_t mem_q [FifoDepth];
  logic [PtrW-1:0]    wr_ptr_q;
  logic [PtrW-1:0]    rd_ptr_q;
  logic [CntW-1:0]    cnt_q;
  logic               pop;

  // ------------------------------
  // Status
  // ------------------------------

  assign valid_o = (cnt_q != '0);
  assign full_o  = (cnt_q == CntW'(FifoDepth));
  assign pop     = valid_o && ready_i;
  // Head entry, held until popped
  assign data_o  = mem_q[rd_ptr_q];

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Wrap at depth, depth need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count only moves on push without pop or pop without push
      if (push_i && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

endmodule

// File: rtl/red_unit_top.sv
// Reduction stage top; NumRoutes 1..8, inputs must stay stable while valid and not yet accepted
`timescale 1ns/1ps

module red_unit_top #(
  parameter int unsigned NumRoutes  = 4,
  parameter bit          EnParallel = 1'b1,
  parameter int unsigned FifoDepth  = 2
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  // Input routes
  input  logic               [NumRoutes-1:0] valid_i,
  output logic               [NumRoutes-1:0] ready_o,
  input  red_pkg::red_flit_t [NumRoutes-1:0] data_i,
  // Output port
  output logic                               valid_o,
  input  logic                               ready_i,
  output red_pkg::red_flit_t                 data_o
);

  red_pkg::red_flit_t b_flit;
  red_pkg::red_flit_t w_flit;
  red_pkg::red_flit_t push_flit;
  logic               push;
  logic               full;

  // ------------------------------
  // Control and operands
  // ------------------------------

  red_operand_if #(.NumRoutes(NumRoutes)) ops_if ();

  red_sync_ctrl #(
    .NumRoutes (NumRoutes)
  ) u_sync_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .data_i   (data_i),
    .ops      (ops_if.ctrl_mp),
    .b_flit_i (b_flit),
    .w_flit_i (w_flit),
    .push_o   (push),
    .flit_o   (push_flit),
    .full_i   (full)
  );

  // Both combiners run in parallel, control picks one
  red_collect_b u_collect_b (
    .ops      (ops_if.comb_mp),
    .b_flit_o (b_flit)
  );

  red_w_combine #(
    .EnParallel (EnParallel)
  ) u_w_combine (
    .ops      (ops_if.comb_mp),
    .w_flit_o (w_flit)
  );

  // Result queue toward the output port
  red_out_fifo #(
    .FifoDepth (FifoDepth)
  ) u_out_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (push),
    .flit_i   (push_flit),
    .full_o   (full),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .data_o   (data_o)
  );

endmodule

// File: dv/red_clk_gen.sv
// Testbench clock and reset; 100 ns period, reset held low for 8 cycles then released 1 ns after an edge
`timescale 1ns/1ps

module red_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release just after an edge so nothing samples it mid-change
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// File: dv/red_unit_tb.sv
// Random test of red_unit_top at default parameters; one group at the inputs at a time, headers consistent
`timescale 1ns/1ps

module red_unit_tb;

  localparam int NR = 4;
  localparam int MaxWait = 200;

  logic                        clk_i;
  logic                        arst_n_i;
  logic               [NR-1:0] valid_i;
  logic               [NR-1:0] ready_o;
  red_pkg::red_flit_t [NR-1:0] data_i;
  logic                        valid_o;
  logic                        ready_i;
  red_pkg::red_flit_t          data_o;

  // Stimulus and back-pressure draw from separate streams
  integer seed    = 32'h630e;
  integer bp_seed = 32'h630e ^ 32'h5a5a;

  int                 n_mismatch;
  int                 n_other;
  bit                 timed_out;
  bit                 held;
  red_pkg::red_flit_t held_flit;
  red_pkg::red_flit_t head;
  // Expected results in acceptance order
  red_pkg::red_flit_t exp_q [$];

  red_clk_gen clk_gen (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  red_unit_top UUT (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .data_i   (data_i),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .data_o   (data_o)
  );

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_flit(input string name, input red_pkg::red_flit_t got,
                            input red_pkg::red_flit_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      n_mismatch++;
    end
  endtask

  task automatic check_resp(input red_pkg::red_resp_e got, input red_pkg::red_resp_e exp);
    if (got !== exp) begin
      $display("MISMATCH data_o.resp got %h expected %h", got, exp);
      n_mismatch++;
    end
  endtask

  task automatic check_mask(input logic [NR-1:0] got, input logic [NR-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH ready_o got %h expected %h", got, exp);
      n_mismatch++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      n_mismatch++;
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Slave errors drawn often so collect_b has something to find
  function automatic red_pkg::red_resp_e draw_resp();
    int r;
    r = $random(seed) & 7;
    if (r < 3) begin
      return red_pkg::slverr;
    end else if (r == 3) begin
      return red_pkg::decerr;
    end else if (r == 4) begin
      return red_pkg::exokay;
    end
    return red_pkg::okay;
  endfunction

  // One clock of waiting for acceptance, sampled at the edge before the inputs move
  task automatic step_accept(input logic [NR-1:0] exp_mask, inout int cyc, output bit done);
    done = 1'b0;
    @(posedge clk_i);
    if (ready_o != '0) begin
      check_mask(ready_o, exp_mask);
      if ((valid_i & exp_mask) != exp_mask) begin
        $display("group was accepted before all of its routes were valid");
        n_other++;
      end
      done = 1'b1;
    end else if (cyc > MaxWait) begin
      $display("TIMEOUT group with mask %h was never accepted", exp_mask);
      n_other++;
      timed_out = 1'b1;
      done      = 1'b1;
    end
    #1;
    cyc++;
  endtask

  task automatic run_group();
    red_pkg::red_flit_t fl [NR];
    red_pkg::red_flit_t exp;
    red_pkg::red_flit_t dec;
    logic [NR-1:0]      mask;
    red_pkg::red_op_e   op;
    logic [5:0]         tag;
    logic               lsb;
    bit                 found;
    bit                 done;
    int                 dly [NR];
    int                 lead;
    int                 decoy;
    int                 cyc;
    mask = NR'($random(seed));
    if (mask == '0) begin
      mask = '1;
    end
    op   = red_pkg::red_op_e'(2'($random(seed)));
    tag  = 6'($random(seed));
    lead = 0;
    // Upper mask bits are junk beyond NumRoutes and must be ignored
    for (int i = NR - 1; i >= 0; i--) begin
      fl[i].hdr.red_op             = op;
      fl[i].hdr.red_mask           = 8'($random(seed));
      fl[i].hdr.red_mask[NR-1:0]   = mask;
      fl[i].hdr.tag                = tag;
      fl[i].payload.w.data         = 32'($random(seed));
      fl[i].payload.b.resp         = draw_resp();
      dly[i]                       = $random(seed) & 3;
      if (mask[i]) begin
        lead = i;
      end
    end
    // Model, lead is the lowest participant
    exp = fl[lead];
    case (op)
      red_pkg::lsb_and: begin
        lsb = 1'b1;
        for (int i = 0; i < NR; i++) begin
          if (mask[i]) begin
            lsb = lsb & fl[i].payload.w.data[0];
          end
        end
        exp.payload.w.data[0] = lsb;
      end
      red_pkg::collect_b: begin
        found = 1'b0;
        for (int i = 0; i < NR; i++) begin
          if (mask[i] && !found && fl[i].payload.b.resp == red_pkg::slverr) begin
            exp   = fl[i];
            found = 1'b1;
          end
        end
      end
      default: exp = fl[lead];
    endcase
    exp_q.push_back(exp);
    // Optional bystander above the lead, a group of its own that must wait its turn
    decoy = -1;
    if (($random(seed) & 1) != 0) begin
      for (int i = NR - 1; i > lead; i--) begin
        if (!mask[i]) begin
          decoy = i;
        end
      end
    end
    if (decoy >= 0) begin
      dec                      = fl[decoy];
      dec.hdr.red_mask[NR-1:0] = NR'(1) << decoy;
      dec.hdr.tag              = tag + 6'd1;
      data_i[decoy]            = dec;
      // Single participant, every operation returns the flit itself
      exp_q.push_back(dec);
    end
    for (int i = 0; i < NR; i++) begin
      if (mask[i]) begin
        data_i[i] = fl[i];
      end
    end
    // Staggered arrival, bystander shows up with the last participant
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      for (int i = 0; i < NR; i++) begin
        if (mask[i] && cyc >= dly[i]) begin
          valid_i[i] = 1'b1;
        end
      end
      if (decoy >= 0 && (valid_i & mask) == mask) begin
        valid_i[decoy] = 1'b1;
      end
      step_accept(mask, cyc, done);
    end
    valid_i = valid_i & ~mask;
    if (decoy >= 0 && !timed_out) begin
      cyc  = 0;
      done = 1'b0;
      while (!done) begin
        step_accept(NR'(1) << decoy, cyc, done);
      end
      valid_i[decoy] = 1'b0;
    end
  endtask

  // ------------------------------
  // Output side
  // ------------------------------

  always @(posedge clk_i) begin
    #1;
    ready_i = ($random(bp_seed) & 3) != 0;
  end

  // Pops the model at every handshake, checks a stalled result holds
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (held && !valid_o) begin
        $display("valid_o dropped before the result was taken");
        n_other++;
      end else if (held) begin
        check_flit("data_o held", data_o, held_flit);
      end
      held = 1'b0;
      if (valid_o && ready_i) begin
        if (exp_q.size() == 0) begin
          $display("output produced a result that no group expected");
          n_other++;
        end else begin
          head = exp_q.pop_front();
          check_flit("data_o", data_o, head);
          if (head.hdr.red_op == red_pkg::collect_b) begin
            check_resp(data_o.payload.b.resp, head.payload.b.resp);
          end
        end
      end else if (valid_o) begin
        held      = 1'b1;
        held_flit = data_o;
      end
    end
  end

  // ------------------------------
  // Sequence
  // ------------------------------

  initial begin
    int cyc;
    valid_i    = '0;
    data_i     = '0;
    ready_i    = 1'b0;
    n_mismatch = 0;
    n_other    = 0;
    timed_out  = 1'b0;
    held       = 1'b0;
    #1;
    cyc = 0;
    while (!arst_n_i && cyc < 20) begin
      @(posedge clk_i);
      cyc++;
    end
    if (!arst_n_i) begin
      $display("reset was never released");
      n_other++;
      timed_out = 1'b1;
    end
    // Idle after reset, nothing offered and nothing produced
    repeat (3) begin
      @(posedge clk_i);
      check_bit("valid_o", valid_o, 1'b0);
      check_mask(ready_o, '0);
    end
    #1;
    for (int g = 0; g < 80 && !timed_out; g++) begin
      run_group();
    end
    cyc = 0;
    while (exp_q.size() != 0 && cyc < MaxWait) begin
      @(posedge clk_i);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d results never left the output port", exp_q.size());
      n_other++;
    end
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/red_pkg.sv
rtl/red_operand_if.sv
rtl/red_sync_ctrl.sv
rtl/red_collect_b.sv
rtl/red_w_combine.sv
rtl/red_out_fifo.sv
rtl/red_unit_top.sv
dv/red_clk_gen.sv
dv/red_unit_tb.sv

// File: Makefile
SIM     := verilator
FLAGS   := --binary --timing -Wno-fatal
TOP     := red_unit_tb
FLIST   := vlog.f
OBJ_DIR := obj_dir
PASS    := all tests passed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
